/* Makefile */
VERILATOR ?= verilator
TOP ?= router_tb
OBJ_DIR ?= obj_dir
FILELIST ?= sources.f
VFLAGS ?= --binary --timing --assert -j 0

SRCS := $(filter %.sv,$(shell cat $(FILELIST)))
HDRS := router_config.svh
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* input_port.sv */
`timescale 1ns/1ps
`include "router_config.svh"

module input_port import router_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      wr_en_in,
	input  flit_t     flit_in,
	input  vc_mask_t  pop,
	output vc_flits_t head_flits,
	output vc_reqs_t  reqs,
	output vc_mask_t  on_off_out
);

	localparam int PTR_W = (`FIFO_DEPTH > 1) ? $clog2(`FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

	// circular pointer advance, depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(`FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	genvar v;
	generate
		for (v = 0; v < `VC_PER_PORT; v++) begin : g_vc
			flit_t            mem [`FIFO_DEPTH];
			logic [PTR_W-1:0] wr_ptr;
			logic [PTR_W-1:0] rd_ptr;
			logic [CNT_W-1:0] count;
			logic             push;
			logic             do_pop;
			logic             on_off_q;

			// flit lands in the FIFO of its own VC
			// writes into a full FIFO are dropped
			assign push   = wr_en_in && (flit_in.vc_id == v) &&
				(count != CNT_W'(`FIFO_DEPTH));
			assign do_pop = pop[v] && (count != '0);

			always_ff @(posedge clk) begin
				if (push)
					mem[wr_ptr] <= flit_in;
			end

			always_ff @(posedge clk, posedge reset) begin
				if (reset) begin
					wr_ptr   <= '0;
					rd_ptr   <= '0;
					count    <= '0;
					on_off_q <= 1'b1;
				end else begin
					if (push)
						wr_ptr <= ptr_inc(wr_ptr);
					if (do_pop)
						rd_ptr <= ptr_inc(rd_ptr);
					count <= count + CNT_W'(push) - CNT_W'(do_pop);
					// off while the reserve is eaten into, one cycle behind count
					on_off_q <= (count < CNT_W'(`FIFO_DEPTH - `ON_OFF_MARGIN));
				end
			end

			assign on_off_out[v] = on_off_q;

			// head flit goes straight to the switch stage
			assign head_flits[v] = mem[rd_ptr];

			// out port was computed one hop earlier
			assign reqs[v].valid    = (count != '0);
			assign reqs[v].out_port = mem[rd_ptr].next_hop_port;
			assign reqs[v].is_head  = (mem[rd_ptr].flit_type == HEADER) ||
				(mem[rd_ptr].flit_type == HT);
			assign reqs[v].is_tail  = (mem[rd_ptr].flit_type == TAIL) ||
				(mem[rd_ptr].flit_type == HT);
		end
	endgenerate

endmodule

/* router_config.svh */
`ifndef ROUTER_CONFIG_SVH
`define ROUTER_CONFIG_SVH

// router geometry
// local plus four mesh directions
`define PORT_NUM 5
`define VC_PER_PORT 2

// input buffering, entries per VC
`define FIFO_DEPTH 4
// free slots kept in reserve while the off level travels upstream
// and flits already in flight still land
`define ON_OFF_MARGIN 2

// flit field widths
// mesh coordinate, per axis
`define COORD_W 2
`define PAYLOAD_W 16

`endif

/* router_pkg.sv */
`include "router_config.svh"

package router_pkg;

	// port index order matches the crossbar and the on/off arrays
	typedef enum logic [2:0] {
		LOCAL = 3'd0,
		EAST  = 3'd1,
		WEST  = 3'd2,
		NORTH = 3'd3,
		SOUTH = 3'd4
	} port_t;

	// HT is a single-flit packet, header and tail at once
	typedef enum logic [1:0] {
		HEADER = 2'd0,
		BODY   = 2'd1,
		TAIL   = 2'd2,
		HT     = 2'd3
	} flit_type_t;

	// ownership of one output VC
	typedef enum logic {
		VC_IDLE = 1'b0,
		VC_BUSY = 1'b1
	} vc_state_t;

	// next_hop_port is the output to take at the router receiving the flit
	typedef struct packed {
		flit_type_t               flit_type;
		logic                     vc_id;
		port_t                    next_hop_port;
		logic [`COORD_W-1:0]      dest_x;
		logic [`COORD_W-1:0]      dest_y;
		logic [`PAYLOAD_W-1:0]    payload;
	} flit_t;

	// request built from the head of one VC FIFO
	typedef struct packed {
		logic  valid;
		port_t out_port;
		logic  is_head;
		logic  is_tail;
	} vc_req_t;

	typedef logic [`VC_PER_PORT-1:0] vc_mask_t;
	typedef vc_mask_t [`PORT_NUM-1:0] port_vc_mask_t;
	typedef flit_t [`VC_PER_PORT-1:0] vc_flits_t;
	typedef vc_req_t [`VC_PER_PORT-1:0] vc_reqs_t;

endpackage

/* router_properties.sv */
`timescale 1ns/1ps
`include "router_config.svh"

module router_properties import router_pkg::*; (
	input logic                  clk,
	input logic                  reset,
	input logic [`PORT_NUM-1:0]  wr_en_out,
	input flit_t [`PORT_NUM-1:0] flit_out,
	input port_vc_mask_t         on_off_in,
	input port_vc_mask_t         vc_grant,
	input vc_reqs_t              reqs [`PORT_NUM]
);

	// granted inputs aimed at each output
	int grant_cnt [`PORT_NUM];

	always_comb begin
		for (int o = 0; o < `PORT_NUM; o++) begin
			grant_cnt[o] = 0;
			for (int i = 0; i < `PORT_NUM; i++) begin
				for (int v = 0; v < `VC_PER_PORT; v++) begin
					if (vc_grant[i][v] && reqs[i][v].out_port == port_t'(o))
						grant_cnt[o] = grant_cnt[o] + 1;
				end
			end
		end
	end

	// switch stage comes out of reset empty
	assert property (@(posedge clk) $fell(reset) |-> (wr_en_out == '0))
		else $error("output write strobe high right after reset");

	for (genvar p = 0; p < `PORT_NUM; p++) begin : g_port
		for (genvar v = 0; v < `VC_PER_PORT; v++) begin : g_vc
			// flit on the link implies downstream was on at grant time
			assert property (@(posedge clk) disable iff (reset)
				(wr_en_out[p] && flit_out[p].vc_id == v) |-> $past(on_off_in[p][v]))
				else $error("flit sent on port %0d vc %0d while it was off", p, v);
		end
		assert property (@(posedge clk) disable iff (reset) grant_cnt[p] <= 1)
			else $error("more than one flit granted to output %0d", p);
	end

endmodule

bind router_top router_properties u_props (
	.clk       (clk),
	.reset     (reset),
	.wr_en_out (wr_en_out),
	.flit_out  (flit_out),
	.on_off_in (on_off_in),
	.vc_grant  (vc_grant),
	.reqs      (reqs)
);

/* router_tb.sv */
`timescale 1ns/1ps
`include "router_config.svh"

module router_tb import router_pkg::*;;

	localparam int NQ = `PORT_NUM * `VC_PER_PORT * `PORT_NUM;
	localparam int MAX_CYCLES = 2000;
	// every buffer entry leaving one per cycle, plus the switch latency
	localparam int DRAIN_CYCLES = `PORT_NUM * `VC_PER_PORT * `FIFO_DEPTH + 2;

	logic                  clk;
	logic                  reset;
	logic [`PORT_NUM-1:0]  wr_en_in;
	flit_t [`PORT_NUM-1:0] flit_in;
	port_vc_mask_t         on_off_in;
	logic [`PORT_NUM-1:0]  wr_en_out;
	flit_t [`PORT_NUM-1:0] flit_out;
	port_vc_mask_t         on_off_out;

	// expected flits per output, VC and source input
	flit_t         exp_q [NQ][$];
	// open packet per output VC to check contiguity
	logic          pkt_open [`PORT_NUM][`VC_PER_PORT];
	int            pkt_src [`PORT_NUM][`VC_PER_PORT];
	// output VCs on which no flit may appear
	port_vc_mask_t held_off;
	logic [31:0]   lfsr_state = 32'h8f49_e1e1;
	string         test_name = "reset";
	int            cycles = 0;

	router_top #(.my_x(1), .my_y(1)) u_dut (
		.clk(clk), .reset(reset), .wr_en_in(wr_en_in), .flit_in(flit_in),
		.on_off_in(on_off_in), .wr_en_out(wr_en_out), .flit_out(flit_out),
		.on_off_out(on_off_out)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles in test %s", cycles, test_name);
			$display("Simulation finished: FAIL");
			$fatal(1, "run did not finish");
		end
	end

	task automatic value_mismatch(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		$display("FAILED %s %s expected %h actual %h", test_name, what, exp, act);
		$display("Simulation finished: FAIL");
		$fatal(1, "value mismatch");
	endtask

	task automatic report_error(input string what);
		$display("error in test %s: %s", test_name, what);
		$display("Simulation finished: FAIL");
		$fatal(1, "check failed");
	endtask

	// galois lfsr stepped once per bit taken
	function automatic logic [12:0] rand_bits13();
		logic [12:0] r;
		for (int b = 0; b < 13; b++) begin
			r[b] = lfsr_state[0];
			lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
		end
		return r;
	endfunction

	// route taken at the neighbor one step toward out
	function automatic port_t expect_route(input port_t out, input int dx, input int dy);
		int x;
		int y;
		x = 1;
		y = 1;
		if (out == LOCAL) return LOCAL;
		if (out == EAST) x = 2;
		if (out == WEST) x = 0;
		if (out == NORTH) y = 2;
		if (out == SOUTH) y = 0;
		if (dx != x) return (dx > x) ? EAST : WEST;
		if (dy != y) return (dy > y) ? NORTH : SOUTH;
		return LOCAL;
	endfunction

	// source input rides in the top payload bits
	function automatic flit_t make_flit(input flit_type_t ft, input int vc, input port_t nh,
		input int dx, input int dy, input int src);
		flit_t f;
		f.flit_type     = ft;
		f.vc_id         = vc[0];
		f.next_hop_port = nh;
		f.dest_x        = dx[`COORD_W-1:0];
		f.dest_y        = dy[`COORD_W-1:0];
		f.payload       = {src[2:0], rand_bits13()};
		return f;
	endfunction

	function automatic int pending();
		int n;
		n = 0;
		for (int q = 0; q < NQ; q++)
			n += exp_q[q].size();
		return n;
	endfunction

	task automatic expect_flit(input int src, input flit_t f);
		flit_t e;
		e = f;
		if (f.flit_type == HEADER || f.flit_type == HT)
			e.next_hop_port = expect_route(f.next_hop_port, f.dest_x, f.dest_y);
		exp_q[(int'(f.next_hop_port) * `VC_PER_PORT + f.vc_id) * `PORT_NUM + src].push_back(e);
	endtask

	// drives up to two inputs for one write cycle starting 1 ns after an edge
	task automatic write_two(input int pa, input flit_t fa, input int pb, input flit_t fb);
		wr_en_in[pa] = 1'b1;
		flit_in[pa]  = fa;
		expect_flit(pa, fa);
		if (pb >= 0) begin
			wr_en_in[pb] = 1'b1;
			flit_in[pb]  = fb;
			expect_flit(pb, fb);
		end
		@(posedge clk);
		#1 wr_en_in = '0;
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (pending() > 0 && n < DRAIN_CYCLES) begin
			@(posedge clk);
			n++;
		end
		assert (pending() == 0) else report_error("expected flits never arrived");
		repeat (2) @(posedge clk);
		#1;
	endtask

	// scoreboard compares on the falling edge where outputs are settled
	always @(negedge clk) begin
		flit_t f;
		flit_t e;
		int    q;
		int    src;
		if (!reset) begin
			for (int o = 0; o < `PORT_NUM; o++) begin
				if (wr_en_out[o]) begin
					f   = flit_out[o];
					src = int'(f.payload[15:13]);
					q   = (o * `VC_PER_PORT + f.vc_id) * `PORT_NUM + src;
					assert (src < `PORT_NUM && exp_q[q].size() > 0)
						else report_error($sformatf("unexpected flit on output %0d", o));
					assert (!held_off[o][f.vc_id])
						else report_error("flit left on a VC held off");
					e = exp_q[q].pop_front();
					assert (f == e) else value_mismatch("flit", 32'(e), 32'(f));
					assert (!pkt_open[o][f.vc_id] || pkt_src[o][f.vc_id] == src)
						else report_error("packets interleaved on one output VC");
					if (f.flit_type == HEADER) begin
						pkt_open[o][f.vc_id] = 1'b1;
						pkt_src[o][f.vc_id]  = src;
					end else if (f.flit_type == TAIL || f.flit_type == HT) begin
						pkt_open[o][f.vc_id] = 1'b0;
					end
				end
			end
		end
	end

	task automatic single_hop();
		test_name = "single_hop";
		assert (on_off_out == '1) else value_mismatch("on_off_out", 32'('1), 32'(on_off_out));
		assert (wr_en_out == '0) else value_mismatch("wr_en_out", 32'h0, 32'(wr_en_out));
		write_two(LOCAL, make_flit(HT, 1, EAST, 3, 2, LOCAL), -1, '0);
		// edge k has captured the write and nothing is out yet
		assert (wr_en_out == '0) else value_mismatch("wr_en_out early", 32'h0, 32'(wr_en_out));
		@(posedge clk);
		#1;
		assert (wr_en_out == 5'b00010) else value_mismatch("wr_en_out", 32'h2, 32'(wr_en_out));
		wait_drain();
	endtask

	task automatic lookahead_rewrite();
		port_t dirs [5] = '{LOCAL, EAST, WEST, NORTH, SOUTH};
		test_name = "lookahead";
		for (int d = 0; d < 5; d++) begin
			for (int k = 0; k < 3; k++)
				write_two(LOCAL, make_flit(HT, k % 2, dirs[d], (d + k) % 4, (3 * k + d) % 4,
					LOCAL), -1, '0);
		end
		write_two(SOUTH, make_flit(HEADER, 0, NORTH, 1, 3, SOUTH), -1, '0);
		write_two(SOUTH, make_flit(BODY, 0, NORTH, 1, 3, SOUTH), -1, '0);
		write_two(SOUTH, make_flit(TAIL, 0, NORTH, 1, 3, SOUTH), -1, '0);
		wait_drain();
	endtask

	task automatic packet_exclusivity();
		flit_type_t ft [3] = '{HEADER, BODY, TAIL};
		test_name = "exclusive";
		for (int k = 0; k < 3; k++)
			write_two(WEST, make_flit(ft[k], 0, EAST, 3, 0, WEST),
				NORTH, make_flit(ft[k], 0, EAST, 2, 2, NORTH));
		wait_drain();
	endtask

	task automatic vc_interleave();
		flit_type_t ft [4] = '{HEADER, BODY, BODY, TAIL};
		test_name = "interleave";
		for (int k = 0; k < 4; k++)
			write_two(WEST, make_flit(ft[k], 0, EAST, 3, 1, WEST),
				SOUTH, make_flit(ft[k], 1, EAST, 2, 3, SOUTH));
		wait_drain();
	endtask

	task automatic backpressure_drain();
		flit_type_t ft [`FIFO_DEPTH] = '{HEADER, BODY, BODY, TAIL};
		logic       exp_on;
		test_name = "backpressure";
		on_off_in[EAST][1] = 1'b0;
		held_off[EAST][1]  = 1'b1;
		for (int k = 0; k < `FIFO_DEPTH; k++) begin
			write_two(LOCAL, make_flit(ft[k], 1, EAST, 3, 3, LOCAL), -1, '0);
			// level trails the occupancy by one edge
			exp_on = (k < `FIFO_DEPTH - `ON_OFF_MARGIN);
			assert (on_off_out[LOCAL][1] == exp_on)
				else value_mismatch("on_off_out", 32'(exp_on), 32'(on_off_out[LOCAL][1]));
		end
		// hold long enough that a leaked flit would show
		repeat (6) @(posedge clk);
		#1 on_off_in[EAST][1] = 1'b1;
		// a grant of the last off cycle would still be on the link
		@(posedge clk);
		#1 held_off[EAST][1] = 1'b0;
		wait_drain();
		assert (on_off_out[LOCAL][1] == 1'b1)
			else value_mismatch("on_off_out", 32'h1, 32'(on_off_out[LOCAL][1]));
	endtask

	initial begin
		reset     = 1'b1;
		wr_en_in  = '0;
		flit_in   = '0;
		on_off_in = '1;
		held_off  = '0;
		for (int o = 0; o < `PORT_NUM; o++) begin
			for (int v = 0; v < `VC_PER_PORT; v++)
				pkt_open[o][v] = 1'b0;
		end
		repeat (4) @(posedge clk);
		#1 reset = 1'b0;
		single_hop();
		lookahead_rewrite();
		packet_exclusivity();
		vc_interleave();
		backpressure_drain();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* router_top.sv */
`timescale 1ns/1ps
`include "router_config.svh"

module router_top import router_pkg::*; #(
	parameter int my_x = 1,
	parameter int my_y = 1
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [`PORT_NUM-1:0]  wr_en_in,
	input  flit_t [`PORT_NUM-1:0] flit_in,
	input  port_vc_mask_t         on_off_in,
	output logic [`PORT_NUM-1:0]  wr_en_out,
	output flit_t [`PORT_NUM-1:0] flit_out,
	output port_vc_mask_t         on_off_out
);

	// FIFO heads toward allocator and switch
	vc_reqs_t      reqs [`PORT_NUM];
	vc_flits_t     head_flits [`PORT_NUM];
	// fed back to pop the FIFOs and forward to pick the flits
	port_vc_mask_t vc_grant;

	genvar i;
	generate
		for (i = 0; i < `PORT_NUM; i++) begin : g_in
			input_port u_input_port (
				.clk        (clk),
				.reset      (reset),
				.wr_en_in   (wr_en_in[i]),
				.flit_in    (flit_in[i]),
				.pop        (vc_grant[i]),
				.head_flits (head_flits[i]),
				.reqs       (reqs[i]),
				.on_off_out (on_off_out[i])
			);
		end
	endgenerate

	// VC ownership and switch arbitration in the same cycle
	vc_switch_allocator u_alloc (
		.clk       (clk),
		.reset     (reset),
		.reqs      (reqs),
		.on_off_in (on_off_in),
		.vc_grant  (vc_grant)
	);

	// registered stage, output one edge after the grant
	switch_traversal #(
		.my_x (my_x),
		.my_y (my_y)
	) u_switch (
		.clk        (clk),
		.reset      (reset),
		.head_flits (head_flits),
		.vc_grant   (vc_grant),
		.wr_en_out  (wr_en_out),
		.flit_out   (flit_out)
	);

endmodule

/* sources.f */
+incdir+.
router_pkg.sv
input_port.sv
vc_switch_allocator.sv
switch_traversal.sv
router_top.sv
router_properties.sv
router_tb.sv

/* switch_traversal.sv */
`timescale 1ns/1ps
`include "router_config.svh"

module switch_traversal import router_pkg::*; #(
	parameter int my_x = 1,
	parameter int my_y = 1
) (
	input  logic                 clk,
	input  logic                 reset,
	input  vc_flits_t            head_flits [`PORT_NUM],
	input  port_vc_mask_t        vc_grant,
	output logic [`PORT_NUM-1:0] wr_en_out,
	output flit_t [`PORT_NUM-1:0] flit_out
);

	flit_t sel_flit [`PORT_NUM];
	flit_t la_flit [`PORT_NUM];
	logic  sel_valid [`PORT_NUM];

	// switch register, one slot per input
	flit_t sw_flit [`PORT_NUM];
	port_t sw_port [`PORT_NUM];
	logic  sw_valid [`PORT_NUM];

	// XY route seen from the neighbor behind out_port
	function automatic port_t la_route(
		input port_t               out_port,
		input logic [`COORD_W-1:0] dx,
		input logic [`COORD_W-1:0] dy
	);
		int nx;
		int ny;
		nx = my_x;
		ny = my_y;
		case (out_port)
			EAST:    nx = my_x + 1;
			WEST:    nx = my_x - 1;
			NORTH:   ny = my_y + 1;
			SOUTH:   ny = my_y - 1;
			default: return LOCAL;
		endcase
		// x first, then y
		if (int'(dx) > nx)
			return EAST;
		if (int'(dx) < nx)
			return WEST;
		if (int'(dy) > ny)
			return NORTH;
		if (int'(dy) < ny)
			return SOUTH;
		return LOCAL;
	endfunction

	// grant is one-hot per input, so an OR-select is enough
	always_comb begin
		for (int i = 0; i < `PORT_NUM; i++) begin
			sel_flit[i]  = '0;
			sel_valid[i] = |vc_grant[i];
			for (int v = 0; v < `VC_PER_PORT; v++) begin
				if (vc_grant[i][v])
					sel_flit[i] = head_flits[i][v];
			end
			la_flit[i] = sel_flit[i];
			// only headers carry a route, body and tail pass untouched
			if (sel_flit[i].flit_type == HEADER || sel_flit[i].flit_type == HT)
				la_flit[i].next_hop_port = la_route(sel_flit[i].next_hop_port,
					sel_flit[i].dest_x, sel_flit[i].dest_y);
		end
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `PORT_NUM; i++) begin
				sw_valid[i] <= 1'b0;
				sw_port[i]  <= LOCAL;
			end
		end else begin
			for (int i = 0; i < `PORT_NUM; i++) begin
				sw_valid[i] <= sel_valid[i];
				// steering uses the route computed upstream, not the rewrite
				sw_port[i]  <= sel_flit[i].next_hop_port;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `PORT_NUM; i++)
			sw_flit[i] <= la_flit[i];
	end

	// crossbar, the allocator leaves at most one input per output
	always_comb begin
		for (int o = 0; o < `PORT_NUM; o++) begin
			wr_en_out[o] = 1'b0;
			flit_out[o]  = '0;
			for (int i = 0; i < `PORT_NUM; i++) begin
				if (sw_valid[i] && sw_port[i] == port_t'(o)) begin
					wr_en_out[o] = 1'b1;
					flit_out[o]  = sw_flit[i];
				end
			end
		end
	end

endmodule

/* vc_switch_allocator.sv */
`timescale 1ns/1ps
`include "router_config.svh"

module vc_switch_allocator import router_pkg::*; (
	input  logic          clk,
	input  logic          reset,
	input  vc_reqs_t      reqs [`PORT_NUM],
	input  port_vc_mask_t on_off_in,
	output port_vc_mask_t vc_grant
);

	localparam int VC_W   = (`VC_PER_PORT > 1) ? $clog2(`VC_PER_PORT) : 1;
	localparam int PORT_W = $bits(port_t);

	// ownership of every output VC
	vc_state_t         state [`PORT_NUM][`VC_PER_PORT];
	port_t             owner [`PORT_NUM][`VC_PER_PORT];
	// round-robin pointers, VC per input and input per output
	logic [VC_W-1:0]   rr_vc [`PORT_NUM];
	logic [PORT_W-1:0] rr_in [`PORT_NUM];

	port_vc_mask_t     elig;
	logic              in_valid [`PORT_NUM];
	logic [VC_W-1:0]   in_vc [`PORT_NUM];
	port_t             in_port [`PORT_NUM];
	logic              out_valid [`PORT_NUM];
	logic [PORT_W-1:0] out_sel [`PORT_NUM];

	// a VC may compete once its output VC is free for a header
	// or already held by this input, and downstream has room
	always_comb begin
		int p;
		for (int i = 0; i < `PORT_NUM; i++) begin
			for (int v = 0; v < `VC_PER_PORT; v++) begin
				p = int'(reqs[i][v].out_port);
				elig[i][v] = 1'b0;
				if (reqs[i][v].valid && p < `PORT_NUM && on_off_in[p][v]) begin
					if (reqs[i][v].is_head)
						elig[i][v] = (state[p][v] == VC_IDLE);
					else
						elig[i][v] = (state[p][v] == VC_BUSY) &&
							(owner[p][v] == port_t'(i));
				end
			end
		end
	end

	// input stage, one VC per input
	always_comb begin
		int idx;
		for (int i = 0; i < `PORT_NUM; i++) begin
			in_valid[i] = 1'b0;
			in_vc[i]    = '0;
			for (int k = 0; k < `VC_PER_PORT; k++) begin
				idx = (int'(rr_vc[i]) + k) % `VC_PER_PORT;
				if (!in_valid[i] && elig[i][idx]) begin
					in_valid[i] = 1'b1;
					in_vc[i]    = VC_W'(idx);
				end
			end
			in_port[i] = reqs[i][in_vc[i]].out_port;
		end
	end

	// output stage, one input per output
	// also settles headers racing for the same idle VC
	always_comb begin
		int idx;
		for (int o = 0; o < `PORT_NUM; o++) begin
			out_valid[o] = 1'b0;
			out_sel[o]   = '0;
			for (int k = 0; k < `PORT_NUM; k++) begin
				idx = (int'(rr_in[o]) + k) % `PORT_NUM;
				if (!out_valid[o] && in_valid[idx] && in_port[idx] == port_t'(o)) begin
					out_valid[o] = 1'b1;
					out_sel[o]   = PORT_W'(idx);
				end
			end
		end
	end

	// grant needs both stages, pops the FIFO and steers the switch
	always_comb begin
		vc_grant = '0;
		for (int o = 0; o < `PORT_NUM; o++) begin
			if (out_valid[o])
				vc_grant[out_sel[o]][in_vc[out_sel[o]]] = 1'b1;
		end
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			for (int p = 0; p < `PORT_NUM; p++) begin
				for (int v = 0; v < `VC_PER_PORT; v++) begin
					state[p][v] <= VC_IDLE;
					owner[p][v] <= LOCAL;
				end
				rr_vc[p] <= '0;
				rr_in[p] <= '0;
			end
		end else begin
			for (int o = 0; o < `PORT_NUM; o++) begin
				if (out_valid[o])
					rr_in[o] <= PORT_W'((int'(out_sel[o]) + 1) % `PORT_NUM);
			end
			for (int i = 0; i < `PORT_NUM; i++) begin
				if (|vc_grant[i]) begin
					rr_vc[i] <= VC_W'((int'(in_vc[i]) + 1) % `VC_PER_PORT);
					// header claims, tail releases, HT ends idle
					if (reqs[i][in_vc[i]].is_head) begin
						state[in_port[i]][in_vc[i]] <= VC_BUSY;
						owner[in_port[i]][in_vc[i]] <= port_t'(i);
					end
					if (reqs[i][in_vc[i]].is_tail)
						state[in_port[i]][in_vc[i]] <= VC_IDLE;
				end
			end
		end
	end

endmodule
